// File: flist.f
+incdir+include
rtl/gpio_pkg.sv
rtl/apb_slv.sv
rtl/apb_gpio.sv
rtl/gpio_top.sv
tb/gpio_properties.sv
tb/tb_gpio.sv

// File: include/gpio_settings.svh
// GPIO peripheral build settings for pin count and APB address and register-index widths
`ifndef GPIO_SETTINGS_SVH
`define GPIO_SETTINGS_SVH

// number of GPIO pins
`define GPIO_WIDTH 12

// APB address width in bits
`define GPIO_ADDR_W 12

// register index width; the index is the address without its low 3 bits,
// so registers sit 8 bytes apart
`define GPIO_IDX_W 9

`endif

// File: rtl/apb_gpio.sv
// GPIO register block with input synchronizer and level interrupts, behind an APB bridge
`timescale 1ns/100ps
`include "gpio_settings.svh"

module apb_gpio (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [`GPIO_ADDR_W-1:0] i_paddr,
  input  logic [31:0]             i_pwdata,
  output logic [31:0]             o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic [`GPIO_WIDTH-1:0]  o_irq
);

  logic                    req_valid;
  logic [`GPIO_ADDR_W-1:0] req_addr;
  logic                    req_write;
  logic [31:0]             req_wdata;
  gpio_pkg::reg_idx_e      req_idx;
  logic                    wr_en;

  logic [`GPIO_WIDTH-1:0]  dir_q;
  logic [`GPIO_WIDTH-1:0]  out_q;
  logic [`GPIO_WIDTH-1:0]  ie_q;
  logic [31:0]             scratch_q;
  logic [`GPIO_WIDTH-1:0]  sync1_q;
  logic [`GPIO_WIDTH-1:0]  sync2_q;
  logic [`GPIO_WIDTH-1:0]  in_q;
  logic [`GPIO_WIDTH-1:0]  irq_q;

  logic                    resp_valid_q;
  logic [31:0]             resp_rdata_q;
  logic                    resp_err_q;
  logic [31:0]             rdata;
  logic                    err;

  apb_slv slv_i (
    .clk         (clk),
    .nrst        (nrst),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_pready    (o_pready),
    .o_pslverr   (o_pslverr),
    .o_req_valid (req_valid),
    .o_req_addr  (req_addr),
    .o_req_write (req_write),
    .o_req_wdata (req_wdata),
    .i_resp_valid(resp_valid_q),
    .i_resp_rdata(resp_rdata_q),
    .i_resp_err  (resp_err_q)
  );

  assign req_idx = gpio_pkg::reg_idx_e'(req_addr[`GPIO_ADDR_W-1:3]); // 8-byte stride
  assign wr_en   = req_valid & req_write;

  // read mux and map check
  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (req_idx)
      gpio_pkg::REG_DIR:     rdata[`GPIO_WIDTH-1:0] = dir_q;
      gpio_pkg::REG_IN:      rdata[`GPIO_WIDTH-1:0] = in_q;
      gpio_pkg::REG_OUT:     rdata[`GPIO_WIDTH-1:0] = out_q;
      gpio_pkg::REG_SCRATCH: rdata = scratch_q;
      gpio_pkg::REG_IE:      rdata[`GPIO_WIDTH-1:0] = ie_q;
      default:               err = 1'b1; // unmapped, data stays zero
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      dir_q        <= '1; // all pins input
      out_q        <= '0;
      ie_q         <= '0;
      scratch_q    <= '0;
      resp_valid_q <= 1'b0;
      resp_err_q   <= 1'b0;
    end else begin
      resp_valid_q <= req_valid; // answer on the next edge
      resp_err_q   <= req_valid & err;
      if (wr_en) begin
        case (req_idx)
          gpio_pkg::REG_DIR:     dir_q     <= req_wdata[`GPIO_WIDTH-1:0];
          gpio_pkg::REG_OUT:     out_q     <= req_wdata[`GPIO_WIDTH-1:0];
          gpio_pkg::REG_SCRATCH: scratch_q <= req_wdata;
          gpio_pkg::REG_IE:      ie_q      <= req_wdata[`GPIO_WIDTH-1:0];
          default: ; // REG_IN is read only
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    resp_rdata_q <= rdata;
  end

  // two-flop sync, capture, then irq one cycle later
  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      sync1_q <= '0;
      sync2_q <= '0;
      in_q    <= '0;
      irq_q   <= '0;
    end else begin
      sync1_q <= i_gpio;
      sync2_q <= sync1_q;
      in_q    <= sync2_q;
      irq_q   <= in_q & ie_q; // level per pin
    end
  end

  assign o_gpio     = out_q;
  assign o_gpio_dir = dir_q;
  assign o_irq      = irq_q;

endmodule

// File: rtl/apb_slv.sv
// APB slave bridge that issues one register request per access phase and returns the response
`timescale 1ns/100ps
`include "gpio_settings.svh"

module apb_slv (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [`GPIO_ADDR_W-1:0] i_paddr,
  input  logic [31:0]             i_pwdata,
  output logic [31:0]             o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  output logic                    o_req_valid,
  output logic [`GPIO_ADDR_W-1:0] o_req_addr,
  output logic                    o_req_write,
  output logic [31:0]             o_req_wdata,
  input  logic                    i_resp_valid,
  input  logic [31:0]             i_resp_rdata,
  input  logic                    i_resp_err
);

  gpio_pkg::apb_state_e state_q;
  gpio_pkg::apb_state_e state_d;
  logic [31:0]          rdata_q;
  logic                 err_q;
  logic                 resp_take;

  // pulse only in the first access cycle
  assign o_req_valid = (state_q == gpio_pkg::ST_IDLE) && i_psel && i_penable;
  assign o_req_addr  = i_paddr;  // master holds these stable
  assign o_req_write = i_pwrite;
  assign o_req_wdata = i_pwdata;

  assign resp_take = (state_q == gpio_pkg::ST_WAIT) && i_resp_valid;

  always_comb begin
    state_d = state_q;
    case (state_q)
      gpio_pkg::ST_IDLE: begin
        if (o_req_valid) begin
          state_d = gpio_pkg::ST_WAIT;
        end
      end
      gpio_pkg::ST_WAIT: begin
        if (i_resp_valid) begin
          state_d = gpio_pkg::ST_RESP;
        end
      end
      gpio_pkg::ST_RESP: state_d = gpio_pkg::ST_IDLE; // transfer ends here
      default:           state_d = gpio_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge nrst) begin
    if (!nrst) begin
      state_q <= gpio_pkg::ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (resp_take) begin
        err_q <= i_resp_err;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resp_take) begin
      rdata_q <= i_resp_rdata; // held until the next response
    end
  end

  assign o_pready  = (state_q == gpio_pkg::ST_RESP);
  assign o_pslverr = o_pready & err_q;
  assign o_prdata  = rdata_q;

endmodule

// File: rtl/gpio_pkg.sv
// GPIO peripheral types for the bridge FSM states and the register map indices
`include "gpio_settings.svh"

package gpio_pkg;

  // bridge FSM
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0, // waiting for an access phase
    ST_WAIT = 2'd1, // request issued, waiting for the register block
    ST_RESP = 2'd2  // pready high for one cycle
  } apb_state_e;

  // register map, 8 bytes per index
  typedef enum logic [`GPIO_IDX_W-1:0] {
    REG_DIR     = `GPIO_IDX_W'd0, // 1 = input
    REG_IN      = `GPIO_IDX_W'd1, // read only
    REG_OUT     = `GPIO_IDX_W'd2,
    REG_SCRATCH = `GPIO_IDX_W'd3, // full 32 bits
    REG_IE      = `GPIO_IDX_W'd4  // irq enable mask
  } reg_idx_e;

endpackage

// File: rtl/gpio_top.sv
// GPIO peripheral top level exposing the APB slave port and the pin ports
`timescale 1ns/100ps
`include "gpio_settings.svh"

module gpio_top (
  input  logic                    clk,
  input  logic                    nrst,
  input  logic                    i_psel,
  input  logic                    i_penable,
  input  logic                    i_pwrite,
  input  logic [`GPIO_ADDR_W-1:0] i_paddr,
  input  logic [31:0]             i_pwdata,
  output logic [31:0]             o_prdata,
  output logic                    o_pready,
  output logic                    o_pslverr,
  input  logic [`GPIO_WIDTH-1:0]  i_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_gpio,
  output logic [`GPIO_WIDTH-1:0]  o_gpio_dir,
  output logic [`GPIO_WIDTH-1:0]  o_irq
);

  apb_gpio gpio_i (
    .clk       (clk),
    .nrst      (nrst),
    .i_psel    (i_psel),
    .i_penable (i_penable),
    .i_pwrite  (i_pwrite),
    .i_paddr   (i_paddr),
    .i_pwdata  (i_pwdata),
    .o_prdata  (o_prdata),
    .o_pready  (o_pready),
    .o_pslverr (o_pslverr),
    .i_gpio    (i_gpio),   // async pins
    .o_gpio    (o_gpio),
    .o_gpio_dir(o_gpio_dir),
    .o_irq     (o_irq)
  );

endmodule

// File: run.sh
#!/bin/sh
# build and run the GPIO testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_gpio

if ! out=$(./obj_dir/Vtb_gpio 2>&1); then
  echo "$out"
  echo "simulation exited with an error"
  exit 1
fi
echo "$out"
echo "$out" | grep -qF "*** TEST PASSED ***"

// File: tb/gpio_properties.sv
// APB bridge assertions on pready width, request timing and reset values
`timescale 1ns/100ps

module gpio_properties (
  input logic clk,
  input logic nrst,
  input logic i_psel,
  input logic i_penable,
  input logic o_pready,
  input logic o_pslverr,
  input logic o_req_valid
);

  a_pready_one_cycle: assert property (
    @(posedge clk) disable iff (!nrst) o_pready |=> !o_pready
  ) else $error("pready stayed high for more than one cycle");

  // request only in the first access cycle, right after setup
  a_req_after_setup: assert property (
    @(posedge clk) disable iff (!nrst) o_req_valid |-> $past(i_psel && !i_penable)
  ) else $error("request pulse raised outside the first access cycle");

  a_reset_quiet: assert property (
    @(posedge clk) !nrst |-> (!o_pready && !o_pslverr)
  ) else $error("pready or pslverr high during reset");

endmodule

bind apb_slv gpio_properties props_i (
  .clk        (clk),
  .nrst       (nrst),
  .i_psel     (i_psel),
  .i_penable  (i_penable),
  .o_pready   (o_pready),
  .o_pslverr  (o_pslverr),
  .o_req_valid(o_req_valid)
);

// File: tb/tb_gpio.sv
// Directed testbench for the APB GPIO peripheral covering registers, pins, irq and errors
`timescale 1ns/100ps
`include "gpio_settings.svh"

module tb_gpio;

  localparam int W  = `GPIO_WIDTH;
  localparam int IW = `GPIO_IDX_W;
  localparam int WATCHDOG_NS = 20000; // ~30 transfers of 5 cycles at 4 ns, wide margin

  logic                    clk;
  logic                    nrst;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`GPIO_ADDR_W-1:0] paddr;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic [W-1:0]            gpio_in;
  logic [W-1:0]            gpio_out;
  logic [W-1:0]            gpio_dir;
  logic [W-1:0]            irq;
  logic [31:0]             lcg_state;
  int                      errors;
  int                      checks;

  gpio_top dut_i (
    .clk       (clk),
    .nrst      (nrst),
    .i_psel    (psel),
    .i_penable (penable),
    .i_pwrite  (pwrite),
    .i_paddr   (paddr),
    .i_pwdata  (pwdata),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .i_gpio    (gpio_in),
    .o_gpio    (gpio_out),
    .o_gpio_dir(gpio_dir),
    .o_irq     (irq)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] pin_word(input logic [W-1:0] v);
    return {{(32-W){1'b0}}, v}; // pin registers read back zero-extended
  endfunction

  task automatic check_reg(input gpio_pkg::reg_idx_e idx, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: o_prdata at %s (index 0x%0h) got 0x%08h expected 0x%08h",
               idx.name(), idx, got, exp);
      errors++;
    end
  endtask

  task automatic check_pins(input string name, input logic [W-1:0] got, input logic [W-1:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s got 0x%03h expected 0x%03h", name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      $display("error: %s got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  // one setup cycle, then access cycles until pready, sampled on the falling edge
  task automatic apb_xfer(input logic wr, input logic [IW-1:0] idx, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    int   cycles;
    logic done;
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= {idx, 3'b000};
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    cycles = 0;
    done   = 1'b0;
    rdata  = '0;
    err    = 1'b0;
    while (!done && cycles < 8) begin
      @(negedge clk);
      cycles++;
      if (pready) begin
        done  = 1'b1;
        rdata = prdata;
        err   = pslverr;
      end
    end
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
    checks++;
    if (!done) begin
      $display("pready never rose within %0d access cycles at index 0x%0h", cycles, idx);
      errors++;
    end else if (cycles != 3) begin
      $display("pready rose on access cycle %0d instead of the third at index 0x%0h",
               cycles, idx);
      errors++;
    end
  endtask

  task automatic apb_write(input logic [IW-1:0] idx, input logic [31:0] data, output logic err);
    logic [31:0] unused_rdata;
    apb_xfer(1'b1, idx, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [IW-1:0] idx, output logic [31:0] data, output logic err);
    apb_xfer(1'b0, idx, 32'h0, data, err);
  endtask

  task automatic read_check(input gpio_pkg::reg_idx_e idx, input logic [31:0] exp,
                            input logic exp_err);
    logic [31:0] d;
    logic        e;
    apb_read(idx, d, e);
    check_reg(idx, d, exp);
    check_flag("o_pslverr", e, exp_err);
  endtask

  task automatic report_test(input string name, input int e0);
    $display("test %-12s done, %0d errors", name, errors - e0);
  endtask

  task automatic test_reset();
    int e0 = errors;
    read_check(gpio_pkg::REG_DIR, pin_word('1), 1'b0);
    read_check(gpio_pkg::REG_OUT, 32'h0, 1'b0);
    read_check(gpio_pkg::REG_SCRATCH, 32'h0, 1'b0);
    read_check(gpio_pkg::REG_IE, 32'h0, 1'b0);
    @(negedge clk);
    check_pins("o_gpio_dir", gpio_dir, '1);
    check_pins("o_gpio", gpio_out, '0);
    check_pins("o_irq", irq, '0);
    report_test("reset", e0);
  endtask

  task automatic test_write_read();
    int          e0 = errors;
    logic [31:0] d_dir;
    logic [31:0] d_out;
    logic [31:0] d_scr;
    logic [31:0] d_ie;
    logic        err;
    d_dir = lcg_next();
    d_out = lcg_next();
    d_scr = lcg_next();
    d_ie  = lcg_next();
    apb_write(gpio_pkg::REG_DIR, d_dir, err);
    apb_write(gpio_pkg::REG_OUT, d_out, err);
    apb_write(gpio_pkg::REG_SCRATCH, d_scr, err);
    apb_write(gpio_pkg::REG_IE, d_ie, err);
    @(negedge clk);
    check_pins("o_gpio_dir", gpio_dir, d_dir[W-1:0]);
    check_pins("o_gpio", gpio_out, d_out[W-1:0]);
    read_check(gpio_pkg::REG_DIR, pin_word(d_dir[W-1:0]), 1'b0);
    read_check(gpio_pkg::REG_OUT, pin_word(d_out[W-1:0]), 1'b0);
    read_check(gpio_pkg::REG_SCRATCH, d_scr, 1'b0); // full width
    read_check(gpio_pkg::REG_IE, pin_word(d_ie[W-1:0]), 1'b0);
    report_test("write_read", e0);
  endtask

  task automatic test_input();
    int          e0 = errors;
    logic [31:0] r;
    logic        err;
    r = lcg_next();
    @(posedge clk);
    gpio_in <= r[W-1:0];
    repeat (6) @(posedge clk); // 3 cycles to the input register
    read_check(gpio_pkg::REG_IN, pin_word(r[W-1:0]), 1'b0);
    apb_write(gpio_pkg::REG_IN, ~pin_word(r[W-1:0]), err);
    check_flag("o_pslverr", err, 1'b0);
    read_check(gpio_pkg::REG_IN, pin_word(r[W-1:0]), 1'b0);
    report_test("input", e0);
  endtask

  task automatic test_irq();
    int          e0 = errors;
    logic [31:0] m;
    logic [31:0] p;
    logic        err;
    m = lcg_next();
    p = lcg_next();
    @(posedge clk);
    gpio_in <= p[W-1:0];
    apb_write(gpio_pkg::REG_IE, m, err);
    repeat (6) @(posedge clk);
    @(negedge clk);
    check_pins("o_irq", irq, p[W-1:0] & m[W-1:0]);
    apb_write(gpio_pkg::REG_IE, 32'h0, err);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_pins("o_irq", irq, '0);
    report_test("irq", e0);
  endtask

  task automatic test_errors();
    int          e0 = errors;
    logic [IW-1:0] bad [3];
    logic [31:0] d_dir;
    logic [31:0] d_out;
    logic [31:0] d_scr;
    logic        err;
    bad[0] = IW'(5);
    bad[1] = IW'(7);
    bad[2] = '1; // top of the map
    d_dir = lcg_next();
    d_out = lcg_next();
    d_scr = lcg_next();
    apb_write(gpio_pkg::REG_DIR, d_dir, err);
    apb_write(gpio_pkg::REG_OUT, d_out, err);
    apb_write(gpio_pkg::REG_SCRATCH, d_scr, err);
    for (int i = 0; i < 3; i++) begin
      read_check(gpio_pkg::reg_idx_e'(bad[i]), 32'h0, 1'b1);
      apb_write(bad[i], lcg_next(), err);
      check_flag("o_pslverr", err, 1'b1);
    end
    read_check(gpio_pkg::REG_DIR, pin_word(d_dir[W-1:0]), 1'b0);
    read_check(gpio_pkg::REG_OUT, pin_word(d_out[W-1:0]), 1'b0);
    read_check(gpio_pkg::REG_SCRATCH, d_scr, 1'b0);
    report_test("errors", e0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lcg_state = 32'h8dc5;
    errors    = 0;
    checks    = 0;
    clk       = 1'b0;
    nrst      = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    gpio_in   = '1; // all pins high, irq then hangs on the enable mask alone
    repeat (16) @(posedge clk);
    nrst <= 1'b1;
    test_reset();
    test_write_read();
    test_input();
    test_irq();
    test_errors();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule
